// File: hdl/rcc_pkg.sv
//////////////////////////////////////////////////////////////////////
// rcc package
// shared constants and types of the peripheral clock and reset
// control: peripheral count, post-reset clock delay, domain and
// register address encodings, arcg state encoding
//////////////////////////////////////////////////////////////////////
`default_nettype none

package rcc_pkg;

  // number of controlled peripherals, one bit per register each
  localparam int num_per = 3;

  // bus clock cycles from peripheral reset release to clock on (arcg)
  localparam int clk_on_delay = 2;

  // power domain a peripheral sits in
  typedef enum logic [1:0] {
    dom_d1 = 2'd0,
    dom_d2 = 2'd1,
    dom_d3 = 2'd2
  } domain_e;

  // register map
  typedef enum logic [2:0] {
    ra_c1_enr   = 3'd0,  // cpu1 run enables
    ra_c1_lpenr = 3'd1,  // cpu1 sleep enables
    ra_c2_enr   = 3'd2,  // cpu2 run enables
    ra_c2_lpenr = 3'd3,  // cpu2 sleep enables
    ra_amenr    = 3'd4,  // autonomous mode enables
    ra_rstr     = 3'd5   // software reset bits that hold a peripheral in reset
  } reg_addr_e;

  // post-reset clock gate states
  typedef enum logic [1:0] {
    rg_hold  = 2'd0,
    rg_count = 2'd1,
    rg_run   = 2'd2
  } rg_state_e;

endpackage

`default_nettype wire

// File: hdl/rcc_per_cfg_if.sv
//////////////////////////////////////////////////////////////////////
// rcc per-peripheral config interface
// carries one peripheral's enable and software reset settings from
// the register block to its clock and reset control block
//////////////////////////////////////////////////////////////////////
`default_nettype none

interface rcc_per_cfg_if;

  logic c1_en;      // cpu1 run enable
  logic c1_lpen;    // cpu1 sleep enable
  logic c2_en;      // cpu2 run enable
  logic c2_lpen;    // cpu2 sleep enable
  logic amen;       // d3 autonomous enable
  logic sft_rst_n;  // active low software reset

  modport regs (output c1_en, c1_lpen, c2_en, c2_lpen, amen, sft_rst_n);
  modport ctrl (input c1_en, c1_lpen, c2_en, c2_lpen, amen, sft_rst_n);

endinterface

`default_nettype wire

// File: hdl/clk_gate_cell.sv
//////////////////////////////////////////////////////////////////////
// clock gate cell
// latch based glitch-free gate with test bypass
//////////////////////////////////////////////////////////////////////
`default_nettype none

module clk_gate_cell (
  input  logic clk_in,
  input  logic en,
  input  logic bypass,
  output logic clk_out
);

  logic en_lat;

  // transparent while clk_in is low, so en only changes between pulses
  always_latch begin
    if (!clk_in) begin
      en_lat <= en | bypass;
    end
  end

  assign clk_out = clk_in & en_lat;  // full pulses only

endmodule

`default_nettype wire

// File: hdl/rst_release_clk_gate.sv
//////////////////////////////////////////////////////////////////////
// reset release clock gate
// keeps the peripheral clock enable low for a fixed number of bus
// clock cycles after the peripheral reset is released (arcg)
//////////////////////////////////////////////////////////////////////
`default_nettype none

module rst_release_clk_gate (
  input  logic bus_clk,  // raw bus clock, never the gated one
  input  logic rst_n,
  input  logic arcg_on,
  output logic clk_en
);

  localparam int cnt_w = $clog2(rcc_pkg::clk_on_delay + 1);

  rcc_pkg::rg_state_e state_q;
  rcc_pkg::rg_state_e state_d;
  logic [cnt_w-1:0]   cnt_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      rcc_pkg::rg_hold:  state_d = rcc_pkg::rg_count;  // first edge after release
      rcc_pkg::rg_count: begin
        if (cnt_q == cnt_w'(rcc_pkg::clk_on_delay - 1)) begin
          state_d = rcc_pkg::rg_run;
        end
      end
      default:           state_d = rcc_pkg::rg_run;
    endcase
  end

  always_ff @(posedge bus_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= rcc_pkg::rg_hold;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == rcc_pkg::rg_hold) begin
        cnt_q <= cnt_w'(1);  // counts the edge that left hold
      end else if (state_q == rcc_pkg::rg_count) begin
        cnt_q <= cnt_q + cnt_w'(1);
      end
    end
  end

  // with arcg off the clock follows the reset directly
  assign clk_en = (state_q == rcc_pkg::rg_run) || (!arcg_on && rst_n);

endmodule

`default_nettype wire

// File: hdl/per_clk_rst_control.sv
//////////////////////////////////////////////////////////////////////
// peripheral clock and reset control
// derives one peripheral's bus clock enable from the cpu and d3
// low-power states, gates the bus clock, and combines the system,
// domain and software resets
//////////////////////////////////////////////////////////////////////
`default_nettype none

module per_clk_rst_control #(
  parameter rcc_pkg::domain_e domain = rcc_pkg::dom_d1,
  parameter bit support_lpen     = 1'b0,
  parameter bit support_amen     = 1'b0,
  parameter bit assigned_to_cpu1 = 1'b0,  // implicitly clocked for cpu1
  parameter bit assigned_to_cpu2 = 1'b0   // implicitly clocked for cpu2
) (
  input  logic             bus_clk,
  input  logic             arst_n,
  rcc_per_cfg_if.ctrl      cfg,
  input  logic             c1_sleep,
  input  logic             c1_deepsleep,
  input  logic             c2_sleep,
  input  logic             c2_deepsleep,
  input  logic             d3_deepsleep,
  input  logic             arcg_on,
  input  logic             testmode,
  input  logic             d1_rst_n,
  input  logic             d2_rst_n,
  output logic             per_clk,
  output logic             per_rst_n
);

  logic c1_lp_ok;
  logic c2_lp_ok;
  logic c1_run;
  logic c2_run;
  logic c1_term;
  logic c2_term;
  logic d3_term;
  logic arcg_en;
  logic clk_en;

  // sleep only stops the clock when low-power enables exist
  if (support_lpen) begin : g_lpen
    assign c1_lp_ok = !c1_sleep || cfg.c1_lpen;
    assign c2_lp_ok = !c2_sleep || cfg.c2_lpen;
  end else begin : g_no_lpen
    assign c1_lp_ok = 1'b1;
    assign c2_lp_ok = 1'b1;
  end

  assign c1_run  = cfg.c1_en || assigned_to_cpu1;
  assign c2_run  = cfg.c2_en || assigned_to_cpu2;
  assign c1_term = c1_run && c1_lp_ok && !c1_deepsleep;
  assign c2_term = c2_run && c2_lp_ok && !c2_deepsleep;

  if (domain == rcc_pkg::dom_d3 && support_amen) begin : g_d3_amen
    assign d3_term = cfg.amen && !d3_deepsleep;  // autonomous mode
  end else begin : g_d3_plain
    assign d3_term = !d3_deepsleep;
  end

  assign clk_en = (c1_term || c2_term || d3_term) && arcg_en;

  clk_gate_cell u_clk_gate (
    .clk_in  (bus_clk),
    .en      (clk_en),
    .bypass  (testmode),
    .clk_out (per_clk)
  );

  // d3 has no domain reset of its own
  if (domain == rcc_pkg::dom_d1) begin : g_rst_d1
    assign per_rst_n = arst_n && d1_rst_n && cfg.sft_rst_n;
  end else if (domain == rcc_pkg::dom_d2) begin : g_rst_d2
    assign per_rst_n = arst_n && d2_rst_n && cfg.sft_rst_n;
  end else begin : g_rst_d3
    assign per_rst_n = arst_n && cfg.sft_rst_n;
  end

  rst_release_clk_gate u_arcg_gate (
    .bus_clk (bus_clk),    // raw clock so the counter keeps running
    .rst_n   (per_rst_n),
    .arcg_on (arcg_on),
    .clk_en  (arcg_en)
  );

endmodule

`default_nettype wire

// File: hdl/rcc_regs.sv
//////////////////////////////////////////////////////////////////////
// rcc enable and reset registers
// six software registers with write strobe and combinational read,
// fanned out per peripheral onto the config interfaces
//////////////////////////////////////////////////////////////////////
`default_nettype none

module rcc_regs (
  input  logic                        bus_clk,
  input  logic                        arst_n,
  input  logic                        reg_wr,
  input  rcc_pkg::reg_addr_e          reg_addr,
  input  logic [rcc_pkg::num_per-1:0] reg_wdata,
  output logic [rcc_pkg::num_per-1:0] reg_rdata,
  rcc_per_cfg_if.regs                 cfg [rcc_pkg::num_per-1:0]
);

  logic [rcc_pkg::num_per-1:0] c1_enr;
  logic [rcc_pkg::num_per-1:0] c1_lpenr;
  logic [rcc_pkg::num_per-1:0] c2_enr;
  logic [rcc_pkg::num_per-1:0] c2_lpenr;
  logic [rcc_pkg::num_per-1:0] amenr;
  logic [rcc_pkg::num_per-1:0] rstr;

  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      c1_enr   <= '0;
      c1_lpenr <= '0;
      c2_enr   <= '0;
      c2_lpenr <= '0;
      amenr    <= '0;
      rstr     <= '0;
    end else if (reg_wr) begin
      case (reg_addr)
        rcc_pkg::ra_c1_enr:   c1_enr   <= reg_wdata;
        rcc_pkg::ra_c1_lpenr: c1_lpenr <= reg_wdata;
        rcc_pkg::ra_c2_enr:   c2_enr   <= reg_wdata;
        rcc_pkg::ra_c2_lpenr: c2_lpenr <= reg_wdata;
        rcc_pkg::ra_amenr:    amenr    <= reg_wdata;
        rcc_pkg::ra_rstr:     rstr     <= reg_wdata;
        default:              ;  // unmapped address drops the write
      endcase
    end
  end

  always_comb begin
    case (reg_addr)
      rcc_pkg::ra_c1_enr:   reg_rdata = c1_enr;
      rcc_pkg::ra_c1_lpenr: reg_rdata = c1_lpenr;
      rcc_pkg::ra_c2_enr:   reg_rdata = c2_enr;
      rcc_pkg::ra_c2_lpenr: reg_rdata = c2_lpenr;
      rcc_pkg::ra_amenr:    reg_rdata = amenr;
      rcc_pkg::ra_rstr:     reg_rdata = rstr;
      default:              reg_rdata = '0;
    endcase
  end

  // bit n goes to peripheral n
  for (genvar n = 0; n < rcc_pkg::num_per; n++) begin : g_fanout
    assign cfg[n].c1_en     = c1_enr[n];
    assign cfg[n].c1_lpen   = c1_lpenr[n];
    assign cfg[n].c2_en     = c2_enr[n];
    assign cfg[n].c2_lpen   = c2_lpenr[n];
    assign cfg[n].amen      = amenr[n];
    assign cfg[n].sft_rst_n = !rstr[n];  // reset bit set holds reset
  end

endmodule

`default_nettype wire

// File: hdl/rcc_per_subsys.sv
//////////////////////////////////////////////////////////////////////
// rcc peripheral subsystem
// register block plus clock and reset control for one peripheral in
// each of the d1, d2 and d3 domains
//////////////////////////////////////////////////////////////////////
`default_nettype none

module rcc_per_subsys (
  input  logic                        bus_clk,
  input  logic                        arst_n,
  input  logic                        reg_wr,
  input  logic [2:0]                  reg_addr,
  input  logic [rcc_pkg::num_per-1:0] reg_wdata,
  output logic [rcc_pkg::num_per-1:0] reg_rdata,
  input  logic                        c1_sleep,
  input  logic                        c1_deepsleep,
  input  logic                        c2_sleep,
  input  logic                        c2_deepsleep,
  input  logic                        d3_deepsleep,
  input  logic                        arcg_on,
  input  logic                        testmode,
  input  logic                        d1_rst_n,
  input  logic                        d2_rst_n,
  output logic [rcc_pkg::num_per-1:0] per_clk,
  output logic [rcc_pkg::num_per-1:0] per_rst_n
);

  rcc_per_cfg_if cfg [rcc_pkg::num_per-1:0] ();

  rcc_regs u_regs (
    .bus_clk   (bus_clk),
    .arst_n    (arst_n),
    .reg_wr    (reg_wr),
    .reg_addr  (rcc_pkg::reg_addr_e'(reg_addr)),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .cfg       (cfg)
  );

  // peripheral 0 in d1 with low-power enables
  per_clk_rst_control #(
    .domain       (rcc_pkg::dom_d1),
    .support_lpen (1'b1)
  ) u_per0 (
    .bus_clk      (bus_clk),
    .arst_n       (arst_n),
    .cfg          (cfg[0]),
    .c1_sleep     (c1_sleep),
    .c1_deepsleep (c1_deepsleep),
    .c2_sleep     (c2_sleep),
    .c2_deepsleep (c2_deepsleep),
    .d3_deepsleep (d3_deepsleep),
    .arcg_on      (arcg_on),
    .testmode     (testmode),
    .d1_rst_n     (d1_rst_n),
    .d2_rst_n     (d2_rst_n),
    .per_clk      (per_clk[0]),
    .per_rst_n    (per_rst_n[0])
  );

  // peripheral 1 in d2, owned by cpu2
  per_clk_rst_control #(
    .domain           (rcc_pkg::dom_d2),
    .support_lpen     (1'b1),
    .assigned_to_cpu2 (1'b1)
  ) u_per1 (
    .bus_clk      (bus_clk),
    .arst_n       (arst_n),
    .cfg          (cfg[1]),
    .c1_sleep     (c1_sleep),
    .c1_deepsleep (c1_deepsleep),
    .c2_sleep     (c2_sleep),
    .c2_deepsleep (c2_deepsleep),
    .d3_deepsleep (d3_deepsleep),
    .arcg_on      (arcg_on),
    .testmode     (testmode),
    .d1_rst_n     (d1_rst_n),
    .d2_rst_n     (d2_rst_n),
    .per_clk      (per_clk[1]),
    .per_rst_n    (per_rst_n[1])
  );

  // peripheral 2 in d3, autonomous mode capable
  per_clk_rst_control #(
    .domain       (rcc_pkg::dom_d3),
    .support_amen (1'b1)
  ) u_per2 (
    .bus_clk      (bus_clk),
    .arst_n       (arst_n),
    .cfg          (cfg[2]),
    .c1_sleep     (c1_sleep),
    .c1_deepsleep (c1_deepsleep),
    .c2_sleep     (c2_sleep),
    .c2_deepsleep (c2_deepsleep),
    .d3_deepsleep (d3_deepsleep),
    .arcg_on      (arcg_on),
    .testmode     (testmode),
    .d1_rst_n     (d1_rst_n),
    .d2_rst_n     (d2_rst_n),
    .per_clk      (per_clk[2]),
    .per_rst_n    (per_rst_n[2])
  );

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
//////////////////////////////////////////////////////////////////////
// testbench clock and reset generator
// bus clock with a 20 unit period, reset held low for two cycles
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic arst_n
);

  localparam int period     = 20;
  localparam int rst_cycles = 2;

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    #(period * rst_cycles);  // lands on a falling edge
    arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: tests/rcc_per_subsys_assert.sv
//////////////////////////////////////////////////////////////////////
// peripheral control assertions
// gated clock stays quiet in reset, arcg gate passes through counting
//////////////////////////////////////////////////////////////////////
`default_nettype none

module rcc_per_subsys_assert (
  input logic               bus_clk,
  input logic               per_clk,
  input logic               per_rst_n,
  input logic               testmode,
  input rcc_pkg::rg_state_e arcg_state
);

  // sampled on the falling edge so per_clk shows the high phase
  property p_no_clk_in_reset;
    @(negedge bus_clk)
      (!per_rst_n && !testmode && !$past(per_rst_n) && !$past(testmode)) |-> !per_clk;
  endproperty

  property p_run_after_count;
    @(posedge bus_clk)
      (arcg_state == rcc_pkg::rg_run) |->
        ($past(arcg_state) == rcc_pkg::rg_count || $past(arcg_state) == rcc_pkg::rg_run);
  endproperty

  a_no_clk_in_reset: assert property (p_no_clk_in_reset)
    else $error("per_clk pulsed while per_rst_n was low");
  a_run_after_count: assert property (p_run_after_count)
    else $error("arcg gate entered run without counting first");

endmodule

bind per_clk_rst_control rcc_per_subsys_assert i_assert (
  .bus_clk    (bus_clk),
  .per_clk    (per_clk),
  .per_rst_n  (per_rst_n),
  .testmode   (testmode),
  .arcg_state (u_arcg_gate.state_q)
);

`default_nettype wire

// File: tests/tb_rcc_per_subsys.sv
//////////////////////////////////////////////////////////////////////
// rcc peripheral subsystem testbench
// table driven: programs the enable registers, sets the low-power and
// reset inputs, then counts gated clock edges of each peripheral
//////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_rcc_per_subsys;

  typedef struct packed {
    logic [5:0][2:0] regs;       // by register address, rstr is the top octal digit
    logic [4:0]      lp;         // c1_sleep c1_deepsleep c2_sleep c2_deepsleep d3_deepsleep
    logic [3:0]      ctl;        // arcg_on testmode d1_rst_n d2_rst_n
    logic [2:0]      exp_clk;    // 1 means the clock runs
    logic [2:0]      exp_rst_n;
  } row_t;

  logic       bus_clk;
  logic       arst_n;
  logic       reg_wr = 1'b0;
  logic [2:0] reg_addr = 3'd0;
  logic [2:0] reg_wdata = 3'd0;
  logic [2:0] reg_rdata;
  logic       c1_sleep = 1'b0;
  logic       c1_deepsleep = 1'b0;
  logic       c2_sleep = 1'b0;
  logic       c2_deepsleep = 1'b0;
  logic       d3_deepsleep = 1'b0;
  logic       arcg_on = 1'b1;
  logic       testmode = 1'b0;
  logic       d1_rst_n = 1'b1;
  logic       d2_rst_n = 1'b1;
  logic [2:0] per_clk;
  logic [2:0] per_rst_n;

  row_t   rows [$];
  string  names [$];
  int     err_cnt = 0;
  int     chk_cnt = 0;
  integer seed = 32'h5529_591b;
  int     edges0 = 0;
  int     edges1 = 0;
  int     edges2 = 0;

  tb_clk_gen i_clk_gen (
    .clk    (bus_clk),
    .arst_n (arst_n)
  );

  rcc_per_subsys i_dut (
    .bus_clk      (bus_clk),
    .arst_n       (arst_n),
    .reg_wr       (reg_wr),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .c1_sleep     (c1_sleep),
    .c1_deepsleep (c1_deepsleep),
    .c2_sleep     (c2_sleep),
    .c2_deepsleep (c2_deepsleep),
    .d3_deepsleep (d3_deepsleep),
    .arcg_on      (arcg_on),
    .testmode     (testmode),
    .d1_rst_n     (d1_rst_n),
    .d2_rst_n     (d2_rst_n),
    .per_clk      (per_clk),
    .per_rst_n    (per_rst_n)
  );

  always @(posedge per_clk[0]) edges0 = edges0 + 1;
  always @(posedge per_clk[1]) edges1 = edges1 + 1;
  always @(posedge per_clk[2]) edges2 = edges2 + 1;

  function automatic int edge_count(input int n);
    case (n)
      0:       return edges0;
      1:       return edges1;
      default: return edges2;
    endcase
  endfunction

  // reference rules: per0 d1 + lpen, per1 d2 + lpen + cpu2, per2 d3 + amen
  function automatic void model_row(input row_t r, output logic [2:0] clk_on,
                                    output logic [2:0] rst_n);
    logic c1_term;
    logic c2_term;
    logic d3_term;
    logic has_lp;
    for (int n = 0; n < 3; n++) begin
      has_lp  = (n != 2);
      c1_term = !r.lp[3] && r.regs[0][n] && (!has_lp || !r.lp[4] || r.regs[1][n]);
      c2_term = !r.lp[1] && (r.regs[2][n] || n == 1) &&
                (!has_lp || !r.lp[2] || r.regs[3][n]);
      d3_term = !r.lp[0] && (n != 2 || r.regs[4][n]);
      case (n)
        0:       rst_n[n] = r.ctl[1] && !r.regs[5][n];
        1:       rst_n[n] = r.ctl[0] && !r.regs[5][n];
        default: rst_n[n] = !r.regs[5][n];
      endcase
      clk_on[n] = r.ctl[2] || (rst_n[n] && (c1_term || c2_term || d3_term));
    end
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge bus_clk);
    end
  endtask

  task automatic add_row(input string name, input logic [17:0] regs, input logic [4:0] lp,
                         input logic [3:0] ctl, input logic [2:0] exp_clk,
                         input logic [2:0] exp_rst_n);
    row_t r;
    r.regs      = regs;
    r.lp        = lp;
    r.ctl       = ctl;
    r.exp_clk   = exp_clk;
    r.exp_rst_n = exp_rst_n;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic build_table();
    row_t       r;
    logic [2:0] clk_on;
    logic [2:0] rst_n;
    // name, regs (rstr amenr c2_lpenr c2_enr c1_lpenr c1_enr), lp, ctl, clk, rst_n
    add_row("idle_d3_deepsleep",   18'o000000, 5'b00001, 4'b1011, 3'b010, 3'b111);
    add_row("c1_run_p0",           18'o000001, 5'b00001, 4'b1011, 3'b011, 3'b111);
    add_row("c2_run_p2",           18'o000400, 5'b00001, 4'b1011, 3'b110, 3'b111);
    add_row("c1_sleep_no_lpen",    18'o000007, 5'b10011, 4'b1011, 3'b100, 3'b111);
    add_row("c1_sleep_lpen",       18'o000077, 5'b10011, 4'b1011, 3'b111, 3'b111);
    add_row("c1_deepsleep",        18'o000077, 5'b01011, 4'b1011, 3'b000, 3'b111);
    add_row("c2_sleep_lpen_p0",    18'o001700, 5'b01101, 4'b1011, 3'b101, 3'b111);
    add_row("d3_amen",             18'o040000, 5'b01010, 4'b1011, 3'b111, 3'b111);
    add_row("d3_no_amen",          18'o000000, 5'b01010, 4'b1011, 3'b011, 3'b111);
    add_row("d3_deepsleep_amen",   18'o040000, 5'b01011, 4'b1011, 3'b000, 3'b111);
    add_row("sw_rst_p0",           18'o100007, 5'b00001, 4'b1011, 3'b110, 3'b110);
    add_row("sw_rst_release",      18'o000007, 5'b00001, 4'b1011, 3'b111, 3'b111);
    add_row("d2_rst",              18'o000007, 5'b00001, 4'b1010, 3'b101, 3'b101);
    add_row("d1_rst_arcg_off",     18'o000007, 5'b00001, 4'b0001, 3'b110, 3'b110);
    add_row("d1_release_arcg_off", 18'o000007, 5'b00001, 4'b0011, 3'b111, 3'b111);
    add_row("testmode",            18'o200000, 5'b11111, 4'b1111, 3'b111, 3'b101);
    for (int k = 0; k < 4; k++) begin
      r.regs = 18'($random(seed));
      r.lp   = 5'($random(seed));
      r.ctl  = 4'b1011;
      model_row(r, clk_on, rst_n);
      add_row($sformatf("random_%0d", k), r.regs, r.lp, r.ctl, clk_on, rst_n);
    end
  endtask

  task automatic apply_row(input int idx);
    row_t r;
    int   start [3];
    r = rows[idx];
    {c1_sleep, c1_deepsleep, c2_sleep, c2_deepsleep, d3_deepsleep} = r.lp;
    {arcg_on, testmode, d1_rst_n, d2_rst_n} = r.ctl;
    for (int a = 0; a < 6; a++) begin
      reg_wr    = 1'b1;
      reg_addr  = 3'(a);
      reg_wdata = r.regs[a];
      @(negedge bus_clk);
    end
    reg_wr = 1'b0;
    for (int a = 0; a < 6; a++) begin
      reg_addr = 3'(a);
      @(negedge bus_clk);
      check($sformatf("%s rd%0d", names[idx], a), 32'(r.regs[a]), 32'(reg_rdata));
    end
    wait_cycles(4);  // covers clk_on_delay and the gate latency
    check($sformatf("%s per_rst_n", names[idx]), 32'(r.exp_rst_n), 32'(per_rst_n));
    for (int n = 0; n < 3; n++) begin
      start[n] = edge_count(n);
    end
    wait_cycles(8);
    for (int n = 0; n < 3; n++) begin
      check($sformatf("%s clk%0d edges", names[idx], n), r.exp_clk[n] ? 8 : 0,
            edge_count(n) - start[n]);
    end
  endtask

  task automatic finish_run();
    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  initial begin
    int guard;
    guard = 0;
    do begin
      @(negedge bus_clk);
      guard++;
    end while (!arst_n && guard < 10);
    if (!arst_n) begin
      $display("timeout: arst_n was never released");
      err_cnt++;
    end else begin
      @(negedge bus_clk);
      check("reset per_rst_n", 32'h7, 32'(per_rst_n));
      for (int a = 0; a < 6; a++) begin
        reg_addr = 3'(a);
        @(negedge bus_clk);
        check($sformatf("reset rd%0d", a), 32'h0, 32'(reg_rdata));
      end
      build_table();
      for (int i = 0; i < rows.size(); i++) begin
        apply_row(i);
      end
    end
    finish_run();
  end

  // watchdog in case the clock or a wait stalls
  initial begin
    #(100_000);
    $display("timeout: simulation ran past its time limit");
    err_cnt++;
    finish_run();
  end

endmodule

`default_nettype wire

// File: compile.f
hdl/rcc_pkg.sv
hdl/rcc_per_cfg_if.sv
hdl/clk_gate_cell.sv
hdl/rst_release_clk_gate.sv
hdl/per_clk_rst_control.sv
hdl/rcc_regs.sv
hdl/rcc_per_subsys.sv
tests/tb_clk_gen.sv
tests/rcc_per_subsys_assert.sv
tests/tb_rcc_per_subsys.sv

// File: Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := tb_rcc_per_subsys
FLIST := compile.f
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD) $(LOG)
